// File: src/sdLvs_config.svh
`ifndef SD_LVS_CONFIG_SVH
`define SD_LVS_CONFIG_SVH

// clk cycles per bus tick
`define SD_BUS_DIV 4

// bus ticks per slow tick, paces the LED countdown
`define SD_SLOW_DIV 8

// bus ticks that sdClk stays high during identification
`define SD_PULSE_TICKS 10

// first value shown on the LEDs
`define SD_COUNT_START 7

`endif

// File: src/sdBusPkg.sv
package sdBusPkg;

    // one bit per DAT lane, lane 0 in bit 0
    typedef logic [3:0] datLanes_t;

    // ==============================
    // pad drive bundle
    // ==============================
    // value and enable for CMD, then value and enable per DAT lane
    typedef struct packed {
        logic      cmdVal;
        logic      cmdOe;
        datLanes_t datVal;
        datLanes_t datOe;
    } padDrive_t;

    // all pins released
    localparam padDrive_t padReleased = '0;

endpackage

// File: src/sdSeqPkg.sv
package sdSeqPkg;

    // ==============================
    // sequencer states
    // ==============================
    typedef enum logic [2:0] {
        stIdle,
        stDrive,
        stCountdown,
        stAllOn,
        stPulseHigh,
        stPulseLow,
        stMirror
    } lvsState_t;

    // commands to the LED panel
    typedef enum logic [2:0] {
        ledHold,
        ledClear,
        ledLoad,
        ledCountDown,
        ledAllOn,
        ledMirror
    } ledCmd_t;

    typedef logic [3:0] ledCode_t;

endpackage

// File: src/sdPinIf.sv
interface sdPinIf;
    import sdBusPkg::*;

    // SD clock level as the sequencer wants it
    logic sdClk;

    // values and enables for CMD and DAT
    padDrive_t drive;

    // card DAT lines after synchronization
    datLanes_t datIn;

    // control side
    modport seq (
        output sdClk,
        output drive,
        input  datIn
    );

    // pad side
    modport pad (
        input  sdClk,
        input  drive,
        output datIn
    );

endinterface

// File: src/sdTickGen.sv
`include "sdLvs_config.svh"

module sdTickGen (
    input  logic clk,
    input  logic rst,
    output logic busTick,
    output logic slowTick
);

    localparam int busCntW  = (`SD_BUS_DIV > 1) ? $clog2(`SD_BUS_DIV) : 1;
    localparam int slowCntW = (`SD_SLOW_DIV > 1) ? $clog2(`SD_SLOW_DIV) : 1;

    logic [busCntW-1:0]  busCnt;
    logic [slowCntW-1:0] slowCnt;

    // ==============================
    // bus rate divider
    // ==============================
    always_ff @(posedge clk) begin
        if (rst || busTick) begin
            busCnt <= '0;
        end else begin
            busCnt <= busCnt + 1'b1;
        end
    end

    assign busTick = (busCnt == busCntW'(`SD_BUS_DIV - 1));

    // slow divider only advances on bus ticks
    always_ff @(posedge clk) begin
        if (rst || slowTick) begin
            slowCnt <= '0;
        end else if (busTick) begin
            slowCnt <= slowCnt + 1'b1;
        end
    end

    assign slowTick = busTick && (slowCnt == slowCntW'(`SD_SLOW_DIV - 1));

endmodule

// File: src/sdPadDriver.sv
module sdPadDriver (
    input  logic               clk,
    input  logic               rst,
    sdPinIf.pad                pins,
    output logic               sdClkPin,
    output logic               cmdOut,
    output logic               cmdOe,
    output sdBusPkg::datLanes_t datOut,
    output sdBusPkg::datLanes_t datOe,
    input  sdBusPkg::datLanes_t datInPin
);
    import sdBusPkg::*;

    datLanes_t datSync1;
    datLanes_t datSync2;

    // ==============================
    // output pads
    // ==============================
    // one register per pin, like an output flop in the IO cell
    always_ff @(posedge clk) begin
        if (rst) begin
            sdClkPin <= 1'b0;
            cmdOut   <= 1'b0;
            cmdOe    <= 1'b0;
            datOut   <= '0;
            datOe    <= '0;
        end else begin
            sdClkPin <= pins.sdClk;
            cmdOut   <= pins.drive.cmdVal;
            cmdOe    <= pins.drive.cmdOe;
            datOut   <= pins.drive.datVal;
            datOe    <= pins.drive.datOe;
        end
    end

    // ==============================
    // input synchronizer
    // ==============================
    // card drives DAT asynchronously to clk
    always_ff @(posedge clk) begin
        datSync1 <= datInPin;
        datSync2 <= datSync1;
    end

    assign pins.datIn = datSync2;

endmodule

// File: src/sdLedPanel.sv
`include "sdLvs_config.svh"

module sdLedPanel (
    input  logic                clk,
    input  logic                rst,
    input  logic                slowTick,
    input  sdSeqPkg::ledCmd_t   ledCmd,
    input  sdBusPkg::datLanes_t datIn,
    output sdSeqPkg::ledCode_t  led,
    output logic                countDone
);
    import sdSeqPkg::*;

    // ==============================
    // LED register
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            led <= '0;
        end else begin
            case (ledCmd)
                ledClear: begin
                    led <= '0;
                end
                ledLoad: begin
                    led <= ledCode_t'(`SD_COUNT_START);
                end
                ledCountDown: begin
                    // one step per slow tick
                    if (slowTick) begin
                        led <= led - ledCode_t'(1);
                    end
                end
                ledAllOn: begin
                    led <= '1;
                end
                ledMirror: begin
                    led <= datIn;
                end
                default: begin
                    led <= led;
                end
            endcase
        end
    end

    // the step that takes the display from 1 to 0
    assign countDone = (ledCmd == ledCountDown) && slowTick && (led == ledCode_t'(1));

endmodule

// File: src/sdLvsSequencer.sv
`include "sdLvs_config.svh"

module sdLvsSequencer (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              busTick,
    input  logic              slowTick,
    input  logic              countDone,
    sdPinIf.seq               pins,
    output sdSeqPkg::ledCmd_t ledCmd,
    output logic              done
);
    import sdBusPkg::*;
    import sdSeqPkg::*;

    localparam int pulseCntW = (`SD_PULSE_TICKS > 1) ? $clog2(`SD_PULSE_TICKS) : 1;

    // CMD low, DAT0/1/3 driven low, DAT2 left to the card
    localparam padDrive_t lvsDrive = '{
        cmdVal: 1'b0,
        cmdOe:  1'b1,
        datVal: 4'b0000,
        datOe:  4'b1011
    };

    lvsState_t            state;
    logic [pulseCntW-1:0] pulseCnt;

    // ==============================
    // state machine
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= stIdle;
            pulseCnt <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (start) begin
                        state <= stDrive;
                    end
                end
                stDrive: begin
                    state <= stCountdown;
                end
                stCountdown: begin
                    if (countDone) begin
                        state <= stAllOn;
                    end
                end
                stAllOn: begin
                    // leaves on a slow tick, so the pulse starts on the bus grid
                    if (slowTick) begin
                        state    <= stPulseHigh;
                        pulseCnt <= '0;
                    end
                end
                stPulseHigh: begin
                    if (busTick) begin
                        if (pulseCnt == pulseCntW'(`SD_PULSE_TICKS - 1)) begin
                            state <= stPulseLow;
                        end else begin
                            pulseCnt <= pulseCnt + 1'b1;
                        end
                    end
                end
                stPulseLow: begin
                    state <= stMirror;
                end
                default: begin
                    // mirror holds until reset
                    state <= state;
                end
            endcase
        end
    end

    // ==============================
    // outputs per state
    // ==============================
    assign pins.sdClk = (state == stPulseHigh);
    assign pins.drive = (state == stIdle) ? padReleased : lvsDrive;
    assign done       = (state == stMirror);

    always_comb begin
        case (state)
            stDrive:     ledCmd = ledLoad;
            stCountdown: ledCmd = ledCountDown;
            stAllOn:     ledCmd = ledAllOn;
            stPulseHigh: ledCmd = ledClear;
            stMirror:    ledCmd = ledMirror;
            default:     ledCmd = ledHold;
        endcase
    end

endmodule

// File: src/sdLvsTop.sv
module sdLvsTop (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic [3:0] datIn,
    output logic       sdClk,
    output logic       cmdOut,
    output logic       cmdOe,
    output logic       done,
    output logic [3:0] datOut,
    output logic [3:0] datOe,
    output logic [3:0] led
);
    import sdSeqPkg::*;

    logic    busTick;
    logic    slowTick;
    logic    countDone;
    ledCmd_t ledCmd;

    sdPinIf pinBus ();

    // ==============================
    // timing
    // ==============================
    sdTickGen tickGen (
        .clk      (clk),
        .rst      (rst),
        .busTick  (busTick),
        .slowTick (slowTick)
    );

    // ==============================
    // control and display
    // ==============================
    sdLvsSequencer sequencer (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .busTick   (busTick),
        .slowTick  (slowTick),
        .countDone (countDone),
        .pins      (pinBus.seq),
        .ledCmd    (ledCmd),
        .done      (done)
    );

    sdLedPanel ledPanel (
        .clk       (clk),
        .rst       (rst),
        .slowTick  (slowTick),
        .ledCmd    (ledCmd),
        .datIn     (pinBus.datIn),
        .led       (led),
        .countDone (countDone)
    );

    // pins
    sdPadDriver padDriver (
        .clk      (clk),
        .rst      (rst),
        .pins     (pinBus.pad),
        .sdClkPin (sdClk),
        .cmdOut   (cmdOut),
        .cmdOe    (cmdOe),
        .datOut   (datOut),
        .datOe    (datOe),
        .datInPin (datIn)
    );

endmodule

// File: test/sdLvsAssertions.sv
module sdLvsAssertions (
    input logic       clk,
    input logic       rst,
    input logic       sdClk,
    input logic       cmdOe,
    input logic       done,
    input logic [3:0] datOe
);

    // ==============================
    // pad enables
    // ==============================
    // DAT2 belongs to the card for the whole run
    dat2Released: assert property (@(posedge clk) disable iff (rst) !datOe[2])
        else $error("DAT2 output enable went high");

    // identification pulse only with CMD already held
    clkAfterCmd: assert property (@(posedge clk) disable iff (rst) $rose(sdClk) |-> cmdOe)
        else $error("sdClk rose while cmdOe was low");

    // ==============================
    // completion
    // ==============================
    doneSticky: assert property (@(posedge clk) disable iff (rst) !$fell(done))
        else $error("done fell after it was raised");

endmodule

bind sdLvsTop sdLvsAssertions lvsChecks (
    .clk   (clk),
    .rst   (rst),
    .sdClk (sdClk),
    .cmdOe (cmdOe),
    .done  (done),
    .datOe (datOe)
);

// File: test/sdLvsTb.sv
`include "sdLvs_config.svh"

module sdLvsTb;

    localparam int numPatterns = 14;
    localparam int slowCycles  = `SD_BUS_DIV * `SD_SLOW_DIV;
    localparam int pulseCycles = `SD_PULSE_TICKS * `SD_BUS_DIV;
    // countdown with all-on and tick alignment, then the pulse and the mirror patterns
    localparam int cycleLimit  = 5 * ((`SD_COUNT_START + 3) * slowCycles + pulseCycles
                                      + numPatterns * 4);

    logic       clk;
    logic       rst;
    logic       start;
    logic [3:0] datIn;
    logic       sdClk;
    logic       cmdOut;
    logic       cmdOe;
    logic       done;
    logic [3:0] datOut;
    logic [3:0] datOe;
    logic [3:0] led;

    // DAT inputs at even entries and expected LED values at odd entries
    logic [3:0] patternMem [0:2*numPatterns-1];
    logic [3:0] ledSeen [$];
    logic [3:0] ledExpect [$];
    logic [3:0] lastLed;
    logic       lastSdClk;
    logic       driveSeen;
    int         cycleCount;
    int         clkRises;
    int         clkHighCycles;
    int         errorCount;
    int         testErrors [0:4];
    int         testsFailed;
    int         startDelay;
    int         seedInit;

    sdLvsTop dut (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .datIn  (datIn),
        .sdClk  (sdClk),
        .cmdOut (cmdOut),
        .cmdOe  (cmdOe),
        .done   (done),
        .datOut (datOut),
        .datOe  (datOe),
        .led    (led)
    );

    // ==============================
    // clock and watchdog
    // ==============================
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the sequence did not complete within %0d clock cycles", cycleLimit);
        $display("Finished with errors");
        $finish;
    end

    // inputs change and outputs are sampled 1 unit after the edge
    task automatic stepCycle();
        @(posedge clk);
        #1;
        if (sdClk && !lastSdClk) begin
            clkRises++;
        end
        if (sdClk) begin
            clkHighCycles++;
        end
        lastSdClk = sdClk;
    endtask

    task automatic reportError(input int testIdx, input string msg);
        errorCount++;
        testErrors[testIdx]++;
        $display("** Error at time %0t: %s", $time, msg);
    endtask

    task automatic finishTest(input int testIdx, input string name);
        if (testErrors[testIdx] == 0) begin
            $display("test %0d %s: passed", testIdx + 1, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: failed with %0d errors", testIdx + 1, name,
                     testErrors[testIdx]);
        end
    endtask

    // LVS pattern with CMD low, DAT0/1/3 driven low and DAT2 released
    task automatic checkDrive(input string when);
        if (cmdOe !== 1'b1 || cmdOut !== 1'b0 || datOe !== 4'b1011 || datOut !== 4'b0000) begin
            reportError(1, $sformatf("drive pattern %s: cmdOe %b cmdOut %b datOe %b datOut %b",
                                     when, cmdOe, cmdOut, datOe, datOut));
        end
    endtask

    // ==============================
    // test sequence
    // ==============================
    initial begin
        rst           = 1'b1;
        start         = 1'b0;
        datIn         = 4'h0;
        lastLed       = 4'h0;
        lastSdClk     = 1'b0;
        driveSeen     = 1'b0;
        clkRises      = 0;
        clkHighCycles = 0;
        errorCount    = 0;
        testsFailed   = 0;
        for (int i = 0; i < 5; i++) begin
            testErrors[i] = 0;
        end
        seedInit   = 32'h7364;
        startDelay = 2 + int'($urandom(seedInit) % 8);
        $readmemh("test/lvsPatterns.mem", patternMem);

        repeat (3) stepCycle();
        rst = 1'b0;

        // idle outputs while start is held off
        repeat (startDelay) begin
            stepCycle();
            if (sdClk !== 1'b0 || cmdOe !== 1'b0 || datOe !== 4'h0 || led !== 4'h0
                    || done !== 1'b0) begin
                reportError(0, $sformatf("not idle: sdClk %b cmdOe %b datOe %b led %h done %b",
                                         sdClk, cmdOe, datOe, led, done));
            end
        end
        finishTest(0, "reset state");

        start = 1'b1;
        while (done !== 1'b1) begin
            stepCycle();
            start = 1'b0;
            if (cmdOe === 1'b1 && !driveSeen) begin
                driveSeen = 1'b1;
                checkDrive("at first enable");
            end
            if (led !== lastLed) begin
                ledSeen.push_back(led);
                lastLed = led;
            end
        end
        checkDrive("at done");
        finishTest(1, "drive pattern");

        // countdown and one all-on step, then cleared for the pulse
        for (int v = `SD_COUNT_START; v >= 0; v--) begin
            ledExpect.push_back(4'(v));
        end
        ledExpect.push_back(4'hf);
        ledExpect.push_back(4'h0);
        if (ledSeen.size() != ledExpect.size()) begin
            reportError(2, $sformatf("saw %0d LED values, expected %0d",
                                     ledSeen.size(), ledExpect.size()));
        end else begin
            for (int i = 0; i < ledExpect.size(); i++) begin
                if (ledSeen[i] !== ledExpect[i]) begin
                    reportError(2, $sformatf("LED step %0d is %h, expected %h",
                                             i, ledSeen[i], ledExpect[i]));
                end
            end
        end
        finishTest(2, "LED sequence");

        for (int i = 0; i < numPatterns; i++) begin
            datIn = patternMem[2*i];
            repeat (4) stepCycle();
            if (led !== patternMem[2*i+1]) begin
                reportError(3, $sformatf("datIn %h gives led %h, expected %h",
                                         patternMem[2*i], led, patternMem[2*i+1]));
            end
        end
        finishTest(3, "mirror");

        if (clkRises != 1) begin
            reportError(4, $sformatf("sdClk rose %0d times, expected once", clkRises));
        end
        if (clkHighCycles != pulseCycles) begin
            reportError(4, $sformatf("sdClk high for %0d cycles, expected %0d",
                                     clkHighCycles, pulseCycles));
        end
        finishTest(4, "clock pulse");

        $display("tests run 5, tests failed %0d, errors %0d", testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: test/lvsPatterns.mem
// column 1: DAT lines driven by the card (hex)
// column 2: LED value expected in the mirror phase (hex)
5 5
a a
f f
0 0
1 1
2 2
4 4
8 8
3 3
c c
7 7
e e
9 9
6 6

// File: sources.f
+incdir+src
src/sdBusPkg.sv
src/sdSeqPkg.sv
src/sdPinIf.sv
src/sdTickGen.sv
src/sdPadDriver.sv
src/sdLedPanel.sv
src/sdLvsSequencer.sv
src/sdLvsTop.sv
test/sdLvsAssertions.sv
test/sdLvsTb.sv

// File: runSim.sh
#!/bin/sh
# build and run the LVS sequencer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f sources.f --top-module sdLvsTb -o simv \
    && ./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null

grep -qx "Finished with no errors" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
